//--- design/sig_consts.svh
`ifndef SIG_CONSTS_SVH
`define SIG_CONSTS_SVH

// Number of independent byte streams, one enable bit each
`define SIG_STREAMS 64

// Matcher state width, holds 0 up to the signature length
`define SIG_STATE_W 3

// Matched packet counter width
`define SIG_CNT_W 16

// Wishbone word address and data widths
`define SIG_WB_AW 2
`define SIG_WB_DW 32

// Register map, word addresses
`define SIG_REG_EN_LO 2'd0
`define SIG_REG_EN_HI 2'd1
`define SIG_REG_COUNT 2'd2

`endif

//--- design/sig_pkg.sv
`include "sig_consts.svh"

package sig_pkg;

   // One byte of packet data, header or payload
   typedef logic [7:0] sig_byte_t;

   // Stream index taken from the header byte
   typedef logic [5:0] stream_id_t;

   // Matcher state
   // 0 is idle, n means the first n signature bytes were seen
   typedef logic [`SIG_STATE_W-1:0] dfa_state_t;

endpackage

//--- design/sig_frame_parser.sv
`timescale 1ns/1ps

module sig_frame_parser
   import sig_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       in_vld,
   input  logic       in_sop,
   input  logic       in_eop,
   input  sig_byte_t  in_data,
   output logic       load_state,
   output stream_id_t stream_id,
   output logic       new_stream,
   output logic       char_vld,
   output sig_byte_t  char_data,
   output logic       eop
);

   // Header byte present in this cycle
   logic hdr_beat;
   // Payload byte present in this cycle
   logic pay_beat;

   assign hdr_beat = in_vld & in_sop;
   assign pay_beat = in_vld & ~in_sop;

   // Control strobes, one cycle behind the input byte
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         load_state <= 1'b0;
         char_vld   <= 1'b0;
         eop        <= 1'b0;
      end
      else
      begin
         // Header turns into a context load request
         load_state <= hdr_beat;
         // Payload turns into a character beat for the matcher
         char_vld   <= pay_beat;
         // End of packet only ever rides on a payload byte
         eop        <= pay_beat & in_eop;
      end
   end

   // Header fields, held until the next header
   always_ff @(posedge clk)
   begin
      if (hdr_beat)
      begin
         // Bits 5..0 carry the stream id
         stream_id  <= stream_id_t'(in_data[5:0]);
         // Bit 7 asks for a fresh matcher state
         new_stream <= in_data[7];
      end
   end

   // Payload byte, only meaningful while char_vld is high
   always_ff @(posedge clk)
   begin
      if (pay_beat)
      begin
         char_data <= in_data;
      end
   end

endmodule

//--- design/sig_dfa.sv
`timescale 1ns/1ps

module sig_dfa
   import sig_pkg::*;
(
   input  dfa_state_t state_in,
   input  sig_byte_t  char_in,
   output dfa_state_t next_state,
   output logic       accept
);

   // Signature is "PASS", four bytes
   localparam dfa_state_t sig_len = dfa_state_t'(4);
   // First signature byte, also the fallback target
   localparam sig_byte_t  sig_first = "P";

   // Byte that continues the signature from the current state
   sig_byte_t expect_byte;
   // Current state is a legal partial match
   logic      state_ok;
   // Input byte continues the partial match
   logic      hit;

   always_comb
   begin
      case (state_in)
         dfa_state_t'(0): expect_byte = "P";
         dfa_state_t'(1): expect_byte = "A";
         dfa_state_t'(2): expect_byte = "S";
         dfa_state_t'(3): expect_byte = "S";
         default:         expect_byte = sig_first;
      endcase
   end

   assign state_ok = (state_in < sig_len);
   assign hit      = state_ok && (char_in == expect_byte);

   always_comb
   begin
      accept     = 1'b0;
      next_state = '0;
      if (hit)
      begin
         if (state_in == sig_len - dfa_state_t'(1))
         begin
            // Full signature seen
            // "PASS" has no self overlap so restart from idle
            accept     = 1'b1;
            next_state = '0;
         end
         else
            next_state = state_in + dfa_state_t'(1);
      end
      else if (char_in == sig_first)
      begin
         // Mismatch on 'P' starts a new attempt
         next_state = dfa_state_t'(1);
      end
      else
         next_state = '0;
   end

endmodule

//--- design/sig_stream_scanner.sv
`timescale 1ns/1ps

`include "sig_consts.svh"

module sig_stream_scanner
   import sig_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   load_state,
   input  stream_id_t             stream_id,
   input  logic                   new_stream,
   input  logic                   char_vld,
   input  sig_byte_t              char_data,
   input  logic                   eop,
   input  logic [`SIG_STREAMS-1:0] stream_en,
   input  logic                   count_clr,
   output logic [`SIG_CNT_W-1:0]  count
);

   // Saved matcher state per stream, written at end of packet
   dfa_state_t ctx_mem [0:`SIG_STREAMS-1];

   // Live matcher state of the packet in flight
   dfa_state_t live_state;
   // Stream of the packet in flight
   stream_id_t cur_id;
   // At least one match seen in the packet so far
   logic       match_flag;

   // Automaton outputs for the current byte
   dfa_state_t next_state;
   logic       accept;
   // Last byte of an enabled packet that matched somewhere
   logic       pkt_hit;

   sig_dfa u_dfa (
      .state_in   (live_state),
      .char_in    (char_data),
      .next_state (next_state),
      .accept     (accept)
   );

   // Enable bit is picked by the latched stream, not the header field
   assign pkt_hit = char_vld && eop && stream_en[cur_id] && (match_flag || accept);

   // Live state and per packet flag
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         live_state <= '0;
         match_flag <= 1'b0;
      end
      else if (load_state)
      begin
         // Restore saved context unless the header opens a new stream
         live_state <= new_stream ? dfa_state_t'(0) : ctx_mem[stream_id];
         match_flag <= 1'b0;
      end
      else if (char_vld)
      begin
         live_state <= next_state;
         if (accept)
            match_flag <= 1'b1;
      end
   end

   // Stream id of the current packet
   always_ff @(posedge clk)
   begin
      if (load_state)
         cur_id <= stream_id;
   end

   // Context save, done for disabled streams as well
   always_ff @(posedge clk)
   begin
      if (char_vld && eop)
         ctx_mem[cur_id] <= next_state;
   end

   // Counted packets, a clear beats a same cycle increment
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         count <= '0;
      else if (count_clr)
         count <= '0;
      else if (pkt_hit)
         count <= count + 1'b1;
   end

endmodule

//--- design/sig_wb_regs.sv
`timescale 1ns/1ps

`include "sig_consts.svh"

module sig_wb_regs (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   wb_cyc,
   input  logic                   wb_stb,
   input  logic                   wb_we,
   input  logic [`SIG_WB_AW-1:0]  wb_adr,
   input  logic [`SIG_WB_DW-1:0]  wb_dat_w,
   input  logic [`SIG_CNT_W-1:0]  count,
   output logic [`SIG_WB_DW-1:0]  wb_dat_r,
   output logic                   wb_ack,
   output logic [`SIG_STREAMS-1:0] stream_en,
   output logic                   count_clr
);

   // Enable bits for streams 31..0 and 63..32
   logic [`SIG_WB_DW-1:0] en_lo;
   logic [`SIG_WB_DW-1:0] en_hi;

   // New request, ack low so back to back strobes get two cycle accesses
   logic                  req;
   logic                  wr;
   // Read data selected by address
   logic [`SIG_WB_DW-1:0] rd_mux;

   assign req = wb_cyc & wb_stb & ~wb_ack;
   assign wr  = req & wb_we;

   assign stream_en = {en_hi, en_lo};

   always_comb
   begin
      case (wb_adr)
         `SIG_REG_EN_LO: rd_mux = en_lo;
         `SIG_REG_EN_HI: rd_mux = en_hi;
         // Counter is zero extended to the bus width
         `SIG_REG_COUNT: rd_mux = {{(`SIG_WB_DW-`SIG_CNT_W){1'b0}}, count};
         default:        rd_mux = '0;
      endcase
   end

   // Handshake, enable words and clear strobe
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wb_ack    <= 1'b0;
         count_clr <= 1'b0;
         en_lo     <= '0;
         en_hi     <= '0;
      end
      else
      begin
         wb_ack    <= req;
         // Any write data clears, pulse lines up with ack
         count_clr <= wr && (wb_adr == `SIG_REG_COUNT);
         if (wr && (wb_adr == `SIG_REG_EN_LO))
            en_lo <= wb_dat_w;
         if (wr && (wb_adr == `SIG_REG_EN_HI))
            en_hi <= wb_dat_w;
      end
   end

   // Read data captured with the request, valid while ack is high
   always_ff @(posedge clk)
   begin
      if (req)
         wb_dat_r <= rd_mux;
   end

endmodule

//--- design/sig_top.sv
`timescale 1ns/1ps

`include "sig_consts.svh"

module sig_top
   import sig_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  in_vld,
   input  logic                  in_sop,
   input  logic                  in_eop,
   input  sig_byte_t             in_data,
   input  logic                  wb_cyc,
   input  logic                  wb_stb,
   input  logic                  wb_we,
   input  logic [`SIG_WB_AW-1:0] wb_adr,
   input  logic [`SIG_WB_DW-1:0] wb_dat_w,
   output logic [`SIG_WB_DW-1:0] wb_dat_r,
   output logic                  wb_ack
);

   // Parser to scanner beats
   logic       load_state;
   stream_id_t stream_id;
   logic       new_stream;
   logic       char_vld;
   sig_byte_t  char_data;
   logic       eop;

   // Register slave and scanner cross connections
   logic [`SIG_STREAMS-1:0] stream_en;
   logic                    count_clr;
   logic [`SIG_CNT_W-1:0]   count;

   sig_frame_parser u_parser (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_vld     (in_vld),
      .in_sop     (in_sop),
      .in_eop     (in_eop),
      .in_data    (in_data),
      .load_state (load_state),
      .stream_id  (stream_id),
      .new_stream (new_stream),
      .char_vld   (char_vld),
      .char_data  (char_data),
      .eop        (eop)
   );

   sig_stream_scanner u_scanner (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_state (load_state),
      .stream_id  (stream_id),
      .new_stream (new_stream),
      .char_vld   (char_vld),
      .char_data  (char_data),
      .eop        (eop),
      .stream_en  (stream_en),
      .count_clr  (count_clr),
      .count      (count)
   );

   sig_wb_regs u_regs (
      .clk       (clk),
      .rst_n     (rst_n),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_w  (wb_dat_w),
      .count     (count),
      .wb_dat_r  (wb_dat_r),
      .wb_ack    (wb_ack),
      .stream_en (stream_en),
      .count_clr (count_clr)
   );

endmodule

//--- bench/tb_sig_top.sv
`timescale 1ns/1ps

`include "sig_consts.svh"

module tb_sig_top;

   // Upper bounds over all tests, bytes incl. headers and idle gaps
   localparam int wd_bytes  = 800;
   // Wishbone accesses, each about three clock cycles
   localparam int wd_access = 64;

   logic                    clk;
   logic                    rst_n;
   logic                    in_vld;
   logic                    in_sop;
   logic                    in_eop;
   logic [7:0]              in_data;
   logic                    wb_cyc;
   logic                    wb_stb;
   logic                    wb_we;
   logic [`SIG_WB_AW-1:0]   wb_adr;
   logic [`SIG_WB_DW-1:0]   wb_dat_w;
   logic [`SIG_WB_DW-1:0]   wb_dat_r;
   logic                    wb_ack;

   // Reference model, saved state per stream, enables, count
   logic [2:0]              exp_state [0:`SIG_STREAMS-1];
   logic [`SIG_STREAMS-1:0] en_model;
   logic [`SIG_CNT_W-1:0]   exp_count;

   logic [31:0]  lfsr;
   int           errors;
   int           checks;
   int           tests;
   int           test_err0;
   string        cur_test;
   event         pkt_done;
   event         cmp_done;
   int           k;
   int           j;
   int           len;
   logic [5:0]   id;
   logic         nw;
   logic [127:0] pay;
   logic [7:0]   opened;
   // Letter table for random payloads, index 0 is 'P'
   logic [31:0]  letters;

   sig_top u_dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_vld   (in_vld),
      .in_sop   (in_sop),
      .in_eop   (in_eop),
      .in_data  (in_data),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Watchdog
   initial
   begin
      #((wd_bytes + 3 * wd_access) * 10 * 2);
      $display("timeout: the run did not finish within the watchdog time");
      $display("Checks failed");
      $finish;
   end

   // Galois LFSR, one step
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // Takes n bits, LSB of the LFSR first, one step per bit
   function automatic logic [7:0] draw_bits(input int n);
      logic [7:0] v;
      int         i;
      v = '0;
      for (i = 0; i < n; i++)
      begin
         v    = {v[6:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
      draw_bits = v;
   endfunction

   // Walks "PASS" over a payload and returns {matched, end state}
   // Payload byte i sits at byte position len-1-i of the vector
   function automatic logic [3:0] ref_scan(input logic [2:0] st, input logic [127:0] p,
                                           input int n);
      logic [31:0] sig;
      logic [7:0]  b;
      logic        hit;
      int          i;
      sig = "PASS";
      hit = 1'b0;
      for (i = 0; i < n; i++)
      begin
         b = p[8*(n-1-i) +: 8];
         if (b == sig[31-8*st -: 8])
            st = st + 3'd1;
         else if (b == "P")
            st = 3'd1;
         else
            st = 3'd0;
         // Full signature, no overlap so back to idle
         if (st == 3'd4)
         begin
            hit = 1'b1;
            st  = 3'd0;
         end
      end
      ref_scan = {hit, st};
   endfunction

   task automatic drive_byte(input logic vld, input logic sop, input logic eop,
                             input logic [7:0] data);
      @(posedge clk);
      #1;
      in_vld  = vld;
      in_sop  = sop;
      in_eop  = eop;
      in_data = data;
   endtask

   // One Wishbone classic access, waits for ack with a cycle limit
   task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] dw,
                            output logic [31:0] dr);
      int n;
      @(posedge clk);
      #1;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = dw;
      n = 0;
      while (!wb_ack && n < 8)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      dr = wb_dat_r;
      // Classic slave acks exactly one cycle after the request
      assert (wb_ack && n == 1)
      else
      begin
         $display("Wishbone access to address %0d not acked in the cycle after the request",
                  adr);
         errors++;
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_write(input logic [1:0] adr, input logic [31:0] dw);
      logic [31:0] unused;
      wb_access(1'b1, adr, dw, unused);
   endtask

   task automatic expect_read(input logic [1:0] adr, input logic [31:0] exp);
      logic [31:0] rd;
      wb_access(1'b0, adr, '0, rd);
      checks++;
      assert (rd == exp)
      else
      begin
         $display("error %s: expected %0h, actual %0h", cur_test, exp, rd);
         errors++;
      end
   endtask

   // Model update first, then header, payload and one idle cycle
   task automatic send_packet(input logic [5:0] sid, input logic fresh,
                              input logic [127:0] p, input int n);
      logic [3:0] r;
      int         i;
      r = ref_scan(fresh ? 3'd0 : exp_state[sid], p, n);
      exp_state[sid] = r[2:0];
      if (r[3] && en_model[sid])
         exp_count = exp_count + 1'b1;
      drive_byte(1'b1, 1'b1, 1'b0, {fresh, 1'b0, sid});
      for (i = 0; i < n; i++)
         drive_byte(1'b1, 1'b0, i == n - 1, p[8*(n-1-i) +: 8]);
      drive_byte(1'b0, 1'b0, 1'b0, 8'h00);
      -> pkt_done;
      @(cmp_done);
   endtask

   task automatic start_test(input string name);
      cur_test  = name;
      test_err0 = errors;
   endtask

   task automatic finish_test;
      tests++;
      $display("test %s: %s", cur_test, (errors == test_err0) ? "ok" : "failed");
   endtask

   // Counter compare after every packet
   initial
   begin
      forever
      begin
         @(pkt_done);
         expect_read(`SIG_REG_COUNT, 32'(exp_count));
         -> cmp_done;
      end
   end

   initial
   begin
      rst_n     = 1'b0;
      in_vld    = 1'b0;
      in_sop    = 1'b0;
      in_eop    = 1'b0;
      in_data   = 8'h00;
      wb_cyc    = 1'b0;
      wb_stb    = 1'b0;
      wb_we     = 1'b0;
      wb_adr    = '0;
      wb_dat_w  = '0;
      lfsr      = 32'hb68de92b;
      letters   = "XSAP";
      errors    = 0;
      checks    = 0;
      tests     = 0;
      exp_count = '0;
      en_model  = '0;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;

      start_test("enable_readback");
      expect_read(`SIG_REG_COUNT, 32'h0);
      wb_write(`SIG_REG_EN_LO, 32'h1234_abcd);
      wb_write(`SIG_REG_EN_HI, 32'h8765_4321);
      expect_read(`SIG_REG_EN_LO, 32'h1234_abcd);
      expect_read(`SIG_REG_EN_HI, 32'h8765_4321);
      finish_test;

      // Streams 0 to 7 enabled for the directed tests
      wb_write(`SIG_REG_EN_LO, 32'h0000_00ff);
      wb_write(`SIG_REG_EN_HI, 32'h0);
      en_model = {32'h0, 32'h0000_00ff};

      start_test("single_match");
      send_packet(6'd1, 1'b1, "xPASSx", 6);
      send_packet(6'd1, 1'b0, "PASSyyPASS", 10);
      send_packet(6'd1, 1'b0, "PAPASS", 6);
      finish_test;

      start_test("split_match");
      send_packet(6'd2, 1'b1, "zzPA", 4);
      send_packet(6'd3, 1'b1, "PAS", 3);
      send_packet(6'd2, 1'b0, "SSq", 3);
      finish_test;

      start_test("new_stream_reset");
      send_packet(6'd4, 1'b1, "qPA", 3);
      send_packet(6'd4, 1'b1, "SSq", 3);
      finish_test;

      start_test("disabled_stream");
      send_packet(6'd40, 1'b1, "PASS", 4);
      send_packet(6'd40, 1'b0, "kPAS", 4);
      // Stream 40 is bit 8 of the high enable word
      wb_write(`SIG_REG_EN_HI, 32'h0000_0100);
      en_model[40] = 1'b1;
      send_packet(6'd40, 1'b0, "S", 1);
      wb_write(`SIG_REG_COUNT, 32'hffff_ffff);
      exp_count = '0;
      expect_read(`SIG_REG_COUNT, 32'h0);
      finish_test;

      start_test("random_traffic");
      wb_write(`SIG_REG_EN_LO, 32'h0000_005b);
      en_model[31:0] = 32'h0000_005b;
      opened = '0;
      for (k = 0; k < 40; k++)
      begin
         id = 6'(draw_bits(3));
         // First packet of a stream always opens it fresh
         nw = (draw_bits(2) == 8'd0) || !opened[id];
         opened[id] = 1'b1;
         len = 1 + draw_bits(4);
         pay = '0;
         for (j = 0; j < len; j++)
            pay = {pay[119:0], letters[8*draw_bits(2) +: 8]};
         send_packet(id, nw, pay, len);
      end
      finish_test;

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

//--- sources.f
+incdir+design
design/sig_pkg.sv
design/sig_frame_parser.sv
design/sig_dfa.sv
design/sig_stream_scanner.sv
design/sig_wb_regs.sv
design/sig_top.sv
bench/tb_sig_top.sv
